//--- sim.f
verilog/osc_bufg_pkg.sv
verilog/spi_cmd_decoder.sv
verilog/osc_bufg_reg_list.sv
verilog/timestamp_counter.sv
verilog/dna_licence_check.sv
verilog/osc_bufg_top.sv
tb/tb_clk_gen.sv
tb/osc_bufg_tb.sv

//--- tb/osc_bufg_tb.sv
// Register slice directed tests
`timescale 1ns/1ps
`default_nettype none

module osc_bufg_tb
	import osc_bufg_pkg::*;
();

	localparam long_reg_t DNA_VALUE    = 64'h9e37_79b9_7f4a_7c15;
	localparam long_reg_t LICENCE_SALT = 64'hc2b2_ae3d_27d4_eb4f;
	// key rule: identifier xor salt, halves swapped
	localparam long_reg_t SALTED       = DNA_VALUE ^ LICENCE_SALT;
	localparam long_reg_t LICENCE_KEY  = {SALTED[31:0], SALTED[63:32]};
	localparam logic [31:0] LFSR_SEED  = 32'hd4f7;
	// sclk half period in clocks, 32 ns
	localparam int SCLK_HALF           = 8;

	logic        clk_osc_bufg;
	logic        reset;
	logic        sclk;
	logic        cs_n;
	logic        mosi;
	logic        miso;
	logic        reset_sensor;
	logic        sensor_init_done;
	logic [31:0] lfsr_state;
	int          error_count;
	int          pass_count;
	short_reg_t  enc_words [4];

	tb_clk_gen #(.RESET_CYCLES(10)) tb_clk_gen_i (
		.o_clk   (clk_osc_bufg),
		.o_reset (reset)
	);

	osc_bufg_top #(
		.DNA_VALUE    (DNA_VALUE),
		.LICENCE_SALT (LICENCE_SALT)
	) dut_i (
		.clk_osc_bufg       (clk_osc_bufg),
		.i_reset            (reset),
		.i_spi_sclk         (sclk),
		.i_spi_cs_n         (cs_n),
		.i_spi_mosi         (mosi),
		.o_spi_miso         (miso),
		.o_reset_sensor     (reset_sensor),
		.o_sensor_init_done (sensor_init_done)
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	// galois form, right shift
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'ha300_0000;
		return n;
	endfunction

	// one lfsr step per bit taken
	task automatic random_word(output short_reg_t w);
		int b;
		w = '0;
		for (b = 0; b < SHORT_REG_WD; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[SHORT_REG_WD-2:0], lfsr_state[0]};
		end
	endtask

	// lands 1 ns after a rising edge
	task automatic wait_clocks(input int n);
		int k;
		for (k = 0; k < n; k++)
			@(posedge clk_osc_bufg);
		#1;
	endtask

	task automatic check_word(input string name, input short_reg_t got, input short_reg_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			error_count++;
		end else
			pass_count++;
	endtask

	task automatic check_long(input string name, input long_reg_t got, input long_reg_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			error_count++;
		end else
			pass_count++;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
			error_count++;
		end else
			pass_count++;
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("test %s: %0d errors", name, error_count - errs_before);
	endtask

	// ----------------------------------------
	// spi host, mode 0, 33 bit frames
	// ----------------------------------------
	task automatic spi_frame(input logic rd, input spi_addr_t addr, input short_reg_t wdata,
		output short_reg_t rdata);
		logic [32:0] frame;
		int i;
		frame = {rd, addr, wdata};
		rdata = '0;
		cs_n = 1'b0;
		wait_clocks(SCLK_HALF);
		for (i = 32; i >= 0; i--) begin
			mosi = frame[i];
			wait_clocks(SCLK_HALF);
			// miso moved on the last fall, sample at the rise
			if (i < SHORT_REG_WD)
				rdata[i] = miso;
			sclk = 1'b1;
			wait_clocks(SCLK_HALF);
			sclk = 1'b0;
		end
		wait_clocks(SCLK_HALF);
		cs_n = 1'b1;
		mosi = 1'b0;
		// gap before the next frame
		wait_clocks(SCLK_HALF);
	endtask

	task automatic spi_write(input spi_addr_t addr, input short_reg_t data);
		short_reg_t unused;
		spi_frame(1'b0, addr, data, unused);
	endtask

	task automatic spi_read(input spi_addr_t addr, output short_reg_t data);
		spi_frame(1'b1, addr, 16'h0000, data);
	endtask

	// four word reads, msw first
	task automatic read_long(input reg_addr_t base, output long_reg_t v);
		short_reg_t w;
		int k;
		v = '0;
		for (k = 0; k < 4; k++) begin
			spi_read(spi_addr_t'(base + k), w);
			v = {v[LONG_REG_WD-SHORT_REG_WD-1:0], w};
		end
	endtask

	task automatic wait_init_done(input logic level, input int limit);
		int n;
		n = 0;
		while (sensor_init_done !== level && n < limit) begin
			wait_clocks(1);
			n++;
		end
		if (sensor_init_done !== level) begin
			$display("Timeout: o_sensor_init_done did not reach %b in %0d clocks", level, limit);
			error_count++;
		end
	endtask

	// high clocks of o_reset_sensor in a fixed window
	task automatic count_reset_pulses(input int window, output int cnt);
		int k;
		cnt = 0;
		for (k = 0; k < window; k++) begin
			wait_clocks(1);
			if (reset_sensor === 1'b1)
				cnt++;
		end
	endtask

	task automatic wait_reset_release(input int limit);
		int n;
		n = 0;
		while (reset !== 1'b0 && n < limit) begin
			wait_clocks(1);
			n++;
		end
		if (reset !== 1'b0) begin
			$display("Timeout: reset was never released");
			error_count++;
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_read_write();
		int errs;
		int k;
		short_reg_t got;
		errs = error_count;
		check_bit("o_sensor_init_done", sensor_init_done, 1'b0);
		check_bit("o_spi_miso", miso, 1'b0);
		spi_write(spi_addr_t'(ADDR_SENSOR_INIT_DONE), 16'h0001);
		wait_init_done(1'b1, 20);
		check_bit("o_sensor_init_done", sensor_init_done, 1'b1);
		for (k = 0; k < 4; k++) begin
			random_word(enc_words[k]);
			spi_write(spi_addr_t'(ADDR_ENCRYPT_W0 + k), enc_words[k]);
		end
		for (k = 0; k < 4; k++) begin
			spi_read(spi_addr_t'(ADDR_ENCRYPT_W0 + k), got);
			check_word("encrypt word", got, enc_words[k]);
		end
		report_test("read_write", errs);
	endtask

	task automatic test_pulses();
		int errs;
		int cnt;
		short_reg_t got;
		errs = error_count;
		// window covers the whole frame
		fork
			spi_write(spi_addr_t'(ADDR_RESET_SENSOR), 16'h0001);
			count_reset_pulses(600, cnt);
		join
		check_word("o_reset_sensor high clocks", short_reg_t'(cnt), 16'd1);
		spi_read(spi_addr_t'(ADDR_RESET_SENSOR), got);
		check_word("reset_sensor readback", got, 16'h0000);
		report_test("pulses", errs);
	endtask

	task automatic test_dna();
		int errs;
		long_reg_t dna;
		short_reg_t got;
		errs = error_count;
		read_long(ADDR_DNA_W0, dna);
		check_long("dna value", dna, DNA_VALUE);
		// nothing mapped here
		spi_read(16'h0055, got);
		check_word("unmapped read", got, 16'h0000);
		report_test("dna", errs);
	endtask

	task automatic test_timestamp();
		int errs;
		long_reg_t first;
		long_reg_t again;
		long_reg_t second;
		errs = error_count;
		spi_write(spi_addr_t'(ADDR_TIMESTAMP_LOAD), 16'h0001);
		read_long(ADDR_TIMESTAMP_W0, first);
		read_long(ADDR_TIMESTAMP_W0, again);
		check_long("timestamp repeat read", again, first);
		spi_write(spi_addr_t'(ADDR_TIMESTAMP_LOAD), 16'h0001);
		read_long(ADDR_TIMESTAMP_W0, second);
		check_bit("timestamp increased", second > first, 1'b1);
		report_test("timestamp", errs);
	endtask

	task automatic test_licence();
		int errs;
		short_reg_t got;
		errs = error_count;
		// 0x164 carries the top word
		spi_write(spi_addr_t'(ADDR_ENCRYPT_W0), LICENCE_KEY[63:48]);
		spi_write(spi_addr_t'(ADDR_ENCRYPT_W1), LICENCE_KEY[47:32]);
		spi_write(spi_addr_t'(ADDR_ENCRYPT_W2), LICENCE_KEY[31:16]);
		spi_write(spi_addr_t'(ADDR_ENCRYPT_W3), LICENCE_KEY[15:0]);
		spi_read(spi_addr_t'(ADDR_ENCRYPT_STATE), got);
		check_word("encrypt state before commit", got, 16'h0000);
		spi_write(spi_addr_t'(ADDR_PARAM_CFG_DONE), 16'h0001);
		spi_read(spi_addr_t'(ADDR_ENCRYPT_STATE), got);
		check_word("encrypt state after commit", got, 16'h0001);
		// working word only, group untouched
		spi_write(spi_addr_t'(ADDR_ENCRYPT_W3), LICENCE_KEY[15:0] ^ 16'h0001);
		spi_read(spi_addr_t'(ADDR_ENCRYPT_STATE), got);
		check_word("encrypt state uncommitted change", got, 16'h0001);
		spi_write(spi_addr_t'(ADDR_PARAM_CFG_DONE), 16'h0001);
		spi_read(spi_addr_t'(ADDR_ENCRYPT_STATE), got);
		check_word("encrypt state wrong key", got, 16'h0000);
		report_test("licence", errs);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		sclk        = 1'b0;
		cs_n        = 1'b1;
		mosi        = 1'b0;
		lfsr_state  = LFSR_SEED;
		error_count = 0;
		pass_count  = 0;
		wait_reset_release(100);
		wait_clocks(4);
		test_read_write();
		test_pulses();
		test_dna();
		test_timestamp();
		test_licence();
		$display("checks passed %0d, failed %0d", pass_count, error_count);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int RESET_CYCLES = 10
)
(
	output logic o_clk,
	output logic o_reset
);

	// 4 ns period
	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// reset held for a fixed number of clocks, released just after an edge
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1;
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- verilog/dna_licence_check.sv
// Device identifier licence check
`timescale 1ns/1ps
`default_nettype none

module dna_licence_check
	import osc_bufg_pkg::*;
#(
	parameter long_reg_t DNA_VALUE    = 64'h0123_4567_89ab_cdef,
	parameter long_reg_t LICENCE_SALT = 64'h5a5a_a5a5_3c3c_c3c3
)
(
	input  logic      clk_osc_bufg,
	input  logic      i_reset,
	input  long_reg_t i_encrypt_reg,
	output long_reg_t o_dna_reg,
	output logic      o_encrypt_state
);

	long_reg_t dna_reg;
	long_reg_t salted;
	long_reg_t expected_key;
	logic      encrypt_state;

	// ----------------------------------------
	// identifier readout
	// ----------------------------------------
	// stands in for the device primitive
	// value shows up the clock after reset
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset)
			dna_reg <= '0;
		else
			dna_reg <= DNA_VALUE;
	end

	assign o_dna_reg = dna_reg;

	// ----------------------------------------
	// key derivation and compare
	// ----------------------------------------
	assign salted = dna_reg ^ LICENCE_SALT;
	// swap the two 32 bit halves
	assign expected_key = {salted[31:0], salted[63:32]};

	// state valid one clock after the group changes
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset)
			encrypt_state <= 1'b0;
		else
			encrypt_state <= (i_encrypt_reg == expected_key);
	end

	assign o_encrypt_state = encrypt_state;

endmodule

`default_nettype wire

//--- verilog/osc_bufg_pkg.sv
// Oscillator domain register slice definitions
`default_nettype none

package osc_bufg_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int SPI_ADDR_WD  = 16;
	localparam int SHORT_REG_WD = 16;
	localparam int LONG_REG_WD  = 64;
	localparam int REG_ADDR_WD  = 9;

	typedef logic [SPI_ADDR_WD-1:0]  spi_addr_t;
	typedef logic [SHORT_REG_WD-1:0] short_reg_t;
	typedef logic [LONG_REG_WD-1:0]  long_reg_t;
	typedef logic [REG_ADDR_WD-1:0]  reg_addr_t;

	// ----------------------------------------
	// address map, low nine bits only
	// ----------------------------------------
	localparam reg_addr_t ADDR_PARAM_CFG_DONE   = 9'h020;
	localparam reg_addr_t ADDR_RESET_SENSOR     = 9'h03a;
	localparam reg_addr_t ADDR_SENSOR_INIT_DONE = 9'h03b;
	localparam reg_addr_t ADDR_TIMESTAMP_LOAD   = 9'h0d0;
	// timestamp words, msw first
	localparam reg_addr_t ADDR_TIMESTAMP_W0     = 9'h0d1;
	localparam reg_addr_t ADDR_TIMESTAMP_W1     = 9'h0d2;
	localparam reg_addr_t ADDR_TIMESTAMP_W2     = 9'h0d3;
	localparam reg_addr_t ADDR_TIMESTAMP_W3     = 9'h0d4;
	// device identifier words
	localparam reg_addr_t ADDR_DNA_W0           = 9'h160;
	localparam reg_addr_t ADDR_DNA_W1           = 9'h161;
	localparam reg_addr_t ADDR_DNA_W2           = 9'h162;
	localparam reg_addr_t ADDR_DNA_W3           = 9'h163;
	// encryption words, 0x164 ends up most significant
	localparam reg_addr_t ADDR_ENCRYPT_W0       = 9'h164;
	localparam reg_addr_t ADDR_ENCRYPT_W1       = 9'h165;
	localparam reg_addr_t ADDR_ENCRYPT_W2       = 9'h166;
	localparam reg_addr_t ADDR_ENCRYPT_W3       = 9'h167;
	localparam reg_addr_t ADDR_ENCRYPT_STATE    = 9'h168;

	// spi frame walker
	typedef enum logic [2:0] {IDLE, CMD, ADDR, DATA, DONE} spi_state_t;

endpackage

`default_nettype wire

//--- verilog/osc_bufg_reg_list.sv
// Oscillator domain register list
`timescale 1ns/1ps
`default_nettype none

module osc_bufg_reg_list
	import osc_bufg_pkg::*;
(
	input  logic       clk_osc_bufg,
	input  logic       i_reset,
	input  logic       i_wr_en,
	input  logic       i_rd_en,
	input  spi_addr_t  i_addr,
	input  short_reg_t i_wr_data,
	input  long_reg_t  i_timestamp,
	input  long_reg_t  i_dna_reg,
	input  logic       i_encrypt_state,
	output logic       o_rd_sel,
	output short_reg_t o_rd_data,
	output logic       o_reset_sensor,
	output logic       o_sensor_init_done,
	output logic       o_timestamp_load,
	output long_reg_t  o_encrypt_reg
);

	logic [1:0] wr_en_shift;
	logic       wr_en_rise;
	reg_addr_t  local_addr;

	logic       param_cfg_done;
	logic       reset_sensor;
	logic       sensor_init_done;
	logic       timestamp_load;
	short_reg_t encrypt_word [4];
	long_reg_t  encrypt_group;

	// only nine address bits are decoded
	assign local_addr = i_addr[REG_ADDR_WD-1:0];

	// ----------------------------------------
	// write side
	// ----------------------------------------
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset)
			wr_en_shift <= '0;
		else
			wr_en_shift <= {wr_en_shift[0], i_wr_en};
	end
	assign wr_en_rise = (wr_en_shift == 2'b01);

	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset) begin
			param_cfg_done   <= 1'b0;
			reset_sensor     <= 1'b0;
			sensor_init_done <= 1'b0;
			timestamp_load   <= 1'b0;
			encrypt_word[0]  <= '0;
			encrypt_word[1]  <= '0;
			encrypt_word[2]  <= '0;
			encrypt_word[3]  <= '0;
		end else if (wr_en_rise) begin
			case (local_addr)
				ADDR_PARAM_CFG_DONE:   param_cfg_done   <= i_wr_data[0];
				ADDR_RESET_SENSOR:     reset_sensor     <= i_wr_data[0];
				ADDR_SENSOR_INIT_DONE: sensor_init_done <= i_wr_data[0];
				ADDR_TIMESTAMP_LOAD:   timestamp_load   <= i_wr_data[0];
				ADDR_ENCRYPT_W0:       encrypt_word[0]  <= i_wr_data;
				ADDR_ENCRYPT_W1:       encrypt_word[1]  <= i_wr_data;
				ADDR_ENCRYPT_W2:       encrypt_word[2]  <= i_wr_data;
				ADDR_ENCRYPT_W3:       encrypt_word[3]  <= i_wr_data;
				default: ;
			endcase
		end else begin
			// pulses live for one clock
			param_cfg_done <= 1'b0;
			reset_sensor   <= 1'b0;
			timestamp_load <= 1'b0;
		end
	end

	// group commit on config done
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset)
			encrypt_group <= '0;
		else if (param_cfg_done)
			encrypt_group <= {encrypt_word[0], encrypt_word[1], encrypt_word[2], encrypt_word[3]};
	end

	assign o_reset_sensor     = reset_sensor;
	assign o_sensor_init_done = sensor_init_done;
	assign o_timestamp_load   = timestamp_load;
	assign o_encrypt_reg      = encrypt_group;

	// ----------------------------------------
	// read mux, combinational
	// ----------------------------------------
	always_comb begin
		o_rd_sel  = 1'b0;
		o_rd_data = '0;
		if (i_rd_en) begin
			o_rd_sel = 1'b1;
			case (local_addr)
				ADDR_PARAM_CFG_DONE:   o_rd_data = short_reg_t'(param_cfg_done);
				ADDR_RESET_SENSOR:     o_rd_data = short_reg_t'(reset_sensor);
				ADDR_SENSOR_INIT_DONE: o_rd_data = short_reg_t'(sensor_init_done);
				ADDR_TIMESTAMP_LOAD:   o_rd_data = short_reg_t'(timestamp_load);
				// snapshot words
				ADDR_TIMESTAMP_W0:     o_rd_data = i_timestamp[63:48];
				ADDR_TIMESTAMP_W1:     o_rd_data = i_timestamp[47:32];
				ADDR_TIMESTAMP_W2:     o_rd_data = i_timestamp[31:16];
				ADDR_TIMESTAMP_W3:     o_rd_data = i_timestamp[15:0];
				// identifier, read only
				ADDR_DNA_W0:           o_rd_data = i_dna_reg[63:48];
				ADDR_DNA_W1:           o_rd_data = i_dna_reg[47:32];
				ADDR_DNA_W2:           o_rd_data = i_dna_reg[31:16];
				ADDR_DNA_W3:           o_rd_data = i_dna_reg[15:0];
				// working words, not the committed group
				ADDR_ENCRYPT_W0:       o_rd_data = encrypt_word[0];
				ADDR_ENCRYPT_W1:       o_rd_data = encrypt_word[1];
				ADDR_ENCRYPT_W2:       o_rd_data = encrypt_word[2];
				ADDR_ENCRYPT_W3:       o_rd_data = encrypt_word[3];
				ADDR_ENCRYPT_STATE:    o_rd_data = short_reg_t'(i_encrypt_state);
				default:               o_rd_sel  = 1'b0;
			endcase
		end
	end

	// a selected read sees no write and one address while it lasts
	rd_sel_needs_rd_en: assert property (@(posedge clk_osc_bufg) disable iff (i_reset)
		o_rd_sel |-> i_rd_en && !i_wr_en && (!$past(i_rd_en) || $stable(i_addr)));

endmodule

`default_nettype wire

//--- verilog/osc_bufg_top.sv
// Oscillator domain register slice top
`timescale 1ns/1ps
`default_nettype none

module osc_bufg_top
	import osc_bufg_pkg::*;
#(
	parameter long_reg_t DNA_VALUE    = 64'h0123_4567_89ab_cdef,
	parameter long_reg_t LICENCE_SALT = 64'h5a5a_a5a5_3c3c_c3c3
)
(
	input  logic clk_osc_bufg,
	input  logic i_reset,
	input  logic i_spi_sclk,
	input  logic i_spi_cs_n,
	input  logic i_spi_mosi,
	output logic o_spi_miso,
	output logic o_reset_sensor,
	output logic o_sensor_init_done
);

	// decoder to register list
	logic       wr_en;
	logic       rd_en;
	spi_addr_t  addr;
	short_reg_t wr_data;
	logic       rd_sel;
	short_reg_t rd_data;
	// register list to side blocks
	logic       timestamp_load;
	long_reg_t  timestamp;
	long_reg_t  dna_reg;
	long_reg_t  encrypt_reg;
	logic       encrypt_state;

	spi_cmd_decoder spi_cmd_decoder_i (
		.clk_osc_bufg (clk_osc_bufg),
		.i_reset      (i_reset),
		.i_spi_sclk   (i_spi_sclk),
		.i_spi_cs_n   (i_spi_cs_n),
		.i_spi_mosi   (i_spi_mosi),
		.i_rd_sel     (rd_sel),
		.i_rd_data    (rd_data),
		.o_spi_miso   (o_spi_miso),
		.o_wr_en      (wr_en),
		.o_rd_en      (rd_en),
		.o_addr       (addr),
		.o_wr_data    (wr_data)
	);

	osc_bufg_reg_list osc_bufg_reg_list_i (
		.clk_osc_bufg       (clk_osc_bufg),
		.i_reset            (i_reset),
		.i_wr_en            (wr_en),
		.i_rd_en            (rd_en),
		.i_addr             (addr),
		.i_wr_data          (wr_data),
		.i_timestamp        (timestamp),
		.i_dna_reg          (dna_reg),
		.i_encrypt_state    (encrypt_state),
		.o_rd_sel           (rd_sel),
		.o_rd_data          (rd_data),
		.o_reset_sensor     (o_reset_sensor),
		.o_sensor_init_done (o_sensor_init_done),
		.o_timestamp_load   (timestamp_load),
		.o_encrypt_reg      (encrypt_reg)
	);

	timestamp_counter timestamp_counter_i (
		.clk_osc_bufg     (clk_osc_bufg),
		.i_reset          (i_reset),
		.i_timestamp_load (timestamp_load),
		.o_timestamp      (timestamp)
	);

	dna_licence_check #(
		.DNA_VALUE    (DNA_VALUE),
		.LICENCE_SALT (LICENCE_SALT)
	) dna_licence_check_i (
		.clk_osc_bufg    (clk_osc_bufg),
		.i_reset         (i_reset),
		.i_encrypt_reg   (encrypt_reg),
		.o_dna_reg       (dna_reg),
		.o_encrypt_state (encrypt_state)
	);

endmodule

`default_nettype wire

//--- verilog/spi_cmd_decoder.sv
// SPI command decoder
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_decoder
	import osc_bufg_pkg::*;
(
	input  logic       clk_osc_bufg,
	input  logic       i_reset,
	input  logic       i_spi_sclk,
	input  logic       i_spi_cs_n,
	input  logic       i_spi_mosi,
	input  logic       i_rd_sel,
	input  short_reg_t i_rd_data,
	output logic       o_spi_miso,
	output logic       o_wr_en,
	output logic       o_rd_en,
	output spi_addr_t  o_addr,
	output short_reg_t o_wr_data
);

	logic [2:0] sclk_sync;
	logic [2:0] cs_n_sync;
	logic [2:0] mosi_sync;
	logic       sclk_d;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       cs_active;
	logic       mosi_bit;
	spi_state_t state;
	logic [3:0] bit_cnt;
	logic       is_read;
	spi_addr_t  addr_shift;
	short_reg_t data_shift;
	short_reg_t miso_shift;
	logic       rd_en_d;
	logic       miso_step;

	// ----------------------------------------
	// pin synchronizers
	// ----------------------------------------
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset) begin
			sclk_sync <= '0;
			cs_n_sync <= '1;
			mosi_sync <= '0;
			sclk_d    <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[1:0], i_spi_sclk};
			cs_n_sync <= {cs_n_sync[1:0], i_spi_cs_n};
			mosi_sync <= {mosi_sync[1:0], i_spi_mosi};
			sclk_d    <= sclk_sync[2];
		end
	end

	// edges of sclk, aligned with cs and mosi
	assign sclk_rise = sclk_sync[2] & ~sclk_d;
	assign sclk_fall = ~sclk_sync[2] & sclk_d;
	assign cs_active = ~cs_n_sync[2];
	assign mosi_bit  = mosi_sync[2];

	// ----------------------------------------
	// frame fsm: flag, 16 addr, 16 data
	// ----------------------------------------
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset) begin
			state   <= IDLE;
			bit_cnt <= '0;
			is_read <= 1'b0;
			o_wr_en <= 1'b0;
			o_rd_en <= 1'b0;
		end else if (!cs_active) begin
			// cs released, drop everything
			state   <= IDLE;
			bit_cnt <= '0;
			o_wr_en <= 1'b0;
			o_rd_en <= 1'b0;
		end else begin
			case (state)
				IDLE: state <= CMD;
				CMD: begin
					if (sclk_rise) begin
						is_read <= mosi_bit;
						bit_cnt <= '0;
						state   <= ADDR;
					end
				end
				ADDR: begin
					if (sclk_rise) begin
						bit_cnt <= bit_cnt + 4'd1;
						// last address bit, read can start now
						if (bit_cnt == 4'd15) begin
							state   <= DATA;
							o_rd_en <= is_read;
						end
					end
				end
				DATA: begin
					if (sclk_rise) begin
						bit_cnt <= bit_cnt + 4'd1;
						if (bit_cnt == 4'd15) begin
							state   <= DONE;
							o_wr_en <= ~is_read;
						end
					end
				end
				// hold until cs goes high
				DONE: state <= DONE;
				default: state <= IDLE;
			endcase
		end
	end

	// payload shifters, msb first
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset) begin
			addr_shift <= '0;
			data_shift <= '0;
		end else begin
			if (state == ADDR && sclk_rise)
				addr_shift <= {addr_shift[SPI_ADDR_WD-2:0], mosi_bit};
			if (state == DATA && sclk_rise)
				data_shift <= {data_shift[SHORT_REG_WD-2:0], mosi_bit};
		end
	end

	assign o_addr    = addr_shift;
	assign o_wr_data = data_shift;

	// ----------------------------------------
	// read data out on miso
	// ----------------------------------------
	assign miso_step = (state == DATA) && is_read && sclk_fall;

	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset) begin
			rd_en_d    <= 1'b0;
			o_spi_miso <= 1'b0;
		end else begin
			rd_en_d <= o_rd_en;
			if (!cs_active)
				o_spi_miso <= 1'b0;
			else if (miso_step)
				o_spi_miso <= miso_shift[SHORT_REG_WD-1];
		end
	end

	// capture one clock after rd_en, unselected reads give zero
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset)
			miso_shift <= '0;
		else if (o_rd_en && !rd_en_d)
			miso_shift <= i_rd_sel ? i_rd_data : '0;
		else if (miso_step)
			miso_shift <= {miso_shift[SHORT_REG_WD-2:0], 1'b0};
	end

	wr_rd_exclusive: assert property (@(posedge clk_osc_bufg) disable iff (i_reset)
		!(o_wr_en && o_rd_en));

endmodule

`default_nettype wire

//--- verilog/timestamp_counter.sv
// Timestamp counter with snapshot
`timescale 1ns/1ps
`default_nettype none

module timestamp_counter
	import osc_bufg_pkg::*;
(
	input  logic      clk_osc_bufg,
	input  logic      i_reset,
	input  logic      i_timestamp_load,
	output long_reg_t o_timestamp
);

	long_reg_t count;
	long_reg_t snapshot;

	// free running, clocks since reset
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset)
			count <= '0;
		else
			count <= count + 64'd1;
	end

	// ----------------------------------------
	// snapshot for coherent word reads
	// ----------------------------------------
	// holds the count of the load clock
	always_ff @(posedge clk_osc_bufg) begin
		if (i_reset)
			snapshot <= '0;
		else if (i_timestamp_load)
			snapshot <= count;
	end

	assign o_timestamp = snapshot;

endmodule

`default_nettype wire
